/* udp_echo_config.svh */
// Echo responder configuration: answered UDP port, local addresses,
// reply TTL, header length and queue depths
`ifndef UDP_ECHO_CONFIG_SVH
`define UDP_ECHO_CONFIG_SVH

// UDP port that gets answered
`define UDP_ECHO_PORT 16'd1234

// Local station addresses
`define LOCAL_MAC 48'h02_00_00_00_00_00
`define LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}

// TTL placed in every reply
`define REPLY_TTL 8'd64

// Ethernet 14 + IPv4 20 + UDP 8
`define HDR_BYTES 42

// Queue depths in entries
`define PAYLOAD_FIFO_DEPTH 2048
`define HDR_FIFO_DEPTH 4

`endif

/* udp_echo_pkg.sv */
// Address and port types, wire-order frame header layout and the
// header union shared by the receive filter and the reply framer
`include "udp_echo_config.svh"

package udp_echo_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Ethernet, IPv4 and UDP headers in the order they appear on the wire
    typedef struct packed {
        // Ethernet
        mac_addr_t   eth_dest;
        mac_addr_t   eth_src;
        logic [15:0] eth_type;
        // IPv4, fixed 20 byte form only
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_length;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_checksum;
        ip_addr_t    ip_src;
        ip_addr_t    ip_dest;
        // UDP
        udp_port_t   udp_src_port;
        udp_port_t   udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } hdr_fields_t;

    // Byte 0 is the first byte on the wire and sits at the top
    typedef logic [0:`HDR_BYTES-1][7:0] hdr_bytes_t;

    // Same 336 bits, seen as named fields or as a byte sequence
    typedef union packed {
        hdr_fields_t fields;
        hdr_bytes_t  bytes;
    } hdr_u;

endpackage

/* sync_fifo.sv */
// Single-clock first-word-fall-through FIFO with valid/ready on both sides
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk_125mhz,
    input  logic             rst_125mhz,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_valid,
    output logic             wr_ready,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             rd_en;

    assign wr_ready = (count != CW'(DEPTH));
    assign rd_valid = (count != '0);
    // Head entry is presented without a read request
    assign rd_data  = mem[rd_ptr];
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* udp_rx_filter.sv */
// Receive filter: collects the frame header, applies the acceptance rule
// and queues the header and payload of frames that get a reply
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_rx_filter
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,

    // Incoming frame byte stream
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,

    // Header queue write side
    output hdr_u       hdr_wr_data,
    output logic       hdr_wr_valid,
    input  logic       hdr_wr_ready,

    // Payload queue write side, last flag on top
    output logic [8:0] pay_wr_data,
    output logic       pay_wr_valid,
    input  logic       pay_wr_ready
);

    localparam logic [1:0] ST_HDR   = 2'd0;
    localparam logic [1:0] ST_FIRST = 2'd1;
    localparam logic [1:0] ST_PAY   = 2'd2;
    localparam logic [1:0] ST_DROP  = 2'd3;

    localparam logic [5:0] LAST_HDR_IDX = 6'(`HDR_BYTES - 1);

    logic [1:0] state;
    logic [5:0] byte_cnt;
    hdr_u       hdr_reg;
    logic       accept;
    logic       take;

    // Only meaningful in ST_FIRST, once all 42 header bytes are in
    assign accept = (hdr_reg.fields.eth_type == 16'h0800) &&
                    (hdr_reg.fields.ip_ver_ihl == 8'h45) &&
                    (hdr_reg.fields.ip_protocol == 8'd17) &&
                    (hdr_reg.fields.ip_dest == `LOCAL_IP) &&
                    (hdr_reg.fields.udp_dest_port == `UDP_ECHO_PORT);

    always_comb begin
        case (state)
            // First payload byte needs room in both queues
            ST_FIRST: in_ready = accept ? (hdr_wr_ready && pay_wr_ready) : 1'b1;
            ST_PAY:   in_ready = pay_wr_ready;
            default:  in_ready = 1'b1;
        endcase
    end

    assign take = in_valid && in_ready;

    // Header and first payload byte are pushed on the same edge
    assign hdr_wr_data  = hdr_reg;
    assign hdr_wr_valid = in_valid && (state == ST_FIRST) && accept && pay_wr_ready;
    assign pay_wr_data  = {in_last, in_data};
    assign pay_wr_valid = in_valid &&
                          (((state == ST_FIRST) && accept && hdr_wr_ready) ||
                           (state == ST_PAY));

    // Header capture, one byte per accepted cycle
    always_ff @(posedge clk_125mhz) begin
        if ((state == ST_HDR) && take) begin
            hdr_reg.bytes[byte_cnt] <= in_data;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state    <= ST_HDR;
            byte_cnt <= '0;
        end else if (take) begin
            case (state)
                ST_HDR: begin
                    if (in_last) begin
                        // Frame ended inside the header
                        byte_cnt <= '0;
                    end else if (byte_cnt == LAST_HDR_IDX) begin
                        byte_cnt <= '0;
                        state    <= ST_FIRST;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                ST_FIRST: begin
                    if (in_last) begin
                        state <= ST_HDR;
                    end else if (accept) begin
                        state <= ST_PAY;
                    end else begin
                        state <= ST_DROP;
                    end
                end
                // Payload forwarding and discard both run to the last byte
                default: begin
                    if (in_last) begin
                        state <= ST_HDR;
                    end
                end
            endcase
        end
    end

endmodule

/* udp_reply_framer.sv */
// Reply framer: builds the reply header with a fresh IPv4 checksum,
// sends it byte by byte, streams the queued payload and drives the LEDs
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_reply_framer
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,

    // Header queue read side
    input  hdr_u       hdr_rd_data,
    input  logic       hdr_rd_valid,
    output logic       hdr_rd_ready,

    // Payload queue read side, last flag on top
    input  logic [8:0] pay_rd_data,
    input  logic       pay_rd_valid,
    output logic       pay_rd_ready,

    // Reply byte stream
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_last,

    output logic [7:0] led
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_HDR  = 2'd1;
    localparam logic [1:0] ST_PAY  = 2'd2;

    localparam logic [5:0] LAST_HDR_IDX = 6'(`HDR_BYTES - 1);

    logic [1:0] state;
    logic [5:0] hdr_idx;
    hdr_u       tx_hdr;
    logic       first_pay;
    logic       out_xfer;
    logic       pay_end;
    logic       hdr_take;

    // Ones' complement of the ones' complement sum, checksum word as zero
    function automatic logic [15:0] ip_checksum(input hdr_fields_t h);
        logic [19:0] sum;
        logic [16:0] fold;
        sum  = 20'({h.ip_ver_ihl, h.ip_tos});
        sum  = sum + 20'(h.ip_length);
        sum  = sum + 20'(h.ip_id);
        sum  = sum + 20'(h.ip_flags_frag);
        sum  = sum + 20'({h.ip_ttl, h.ip_protocol});
        sum  = sum + 20'(h.ip_src[31:16]);
        sum  = sum + 20'(h.ip_src[15:0]);
        sum  = sum + 20'(h.ip_dest[31:16]);
        sum  = sum + 20'(h.ip_dest[15:0]);
        // Two end-around folds are enough for nine words
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        fold = 17'(fold[15:0]) + 17'(fold[16]);
        return ~fold[15:0];
    endfunction

    // Swap addresses and ports, everything else fixed or copied
    function automatic hdr_u build_reply(input hdr_u rx);
        hdr_u tx;
        tx.fields.eth_dest      = rx.fields.eth_src;
        tx.fields.eth_src       = `LOCAL_MAC;
        tx.fields.eth_type      = 16'h0800;
        tx.fields.ip_ver_ihl    = 8'h45;
        tx.fields.ip_tos        = 8'h00;
        tx.fields.ip_length     = rx.fields.ip_length;
        tx.fields.ip_id         = 16'h0000;
        tx.fields.ip_flags_frag = 16'h0000;
        tx.fields.ip_ttl        = `REPLY_TTL;
        tx.fields.ip_protocol   = 8'd17;
        tx.fields.ip_src        = `LOCAL_IP;
        tx.fields.ip_dest       = rx.fields.ip_src;
        tx.fields.udp_src_port  = rx.fields.udp_dest_port;
        tx.fields.udp_dest_port = rx.fields.udp_src_port;
        tx.fields.udp_length    = rx.fields.udp_length;
        tx.fields.udp_checksum  = 16'h0000;
        tx.fields.ip_checksum   = ip_checksum(tx.fields);
        return tx;
    endfunction

    assign out_xfer     = out_valid && out_ready;
    assign pay_end      = (state == ST_PAY) && out_xfer && pay_rd_data[8];
    // Next header is picked up right on the last payload byte
    assign hdr_rd_ready = (state == ST_IDLE) || pay_end;
    assign hdr_take     = hdr_rd_valid && hdr_rd_ready;
    assign pay_rd_ready = (state == ST_PAY) && out_ready;

    always_comb begin
        out_valid = 1'b0;
        out_data  = pay_rd_data[7:0];
        out_last  = 1'b0;
        if (state == ST_HDR) begin
            out_valid = 1'b1;
            out_data  = tx_hdr.bytes[hdr_idx];
        end else if (state == ST_PAY) begin
            out_valid = pay_rd_valid;
            out_last  = pay_rd_data[8];
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (hdr_take) begin
            tx_hdr <= build_reply(hdr_rd_data);
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state     <= ST_IDLE;
            hdr_idx   <= '0;
            first_pay <= 1'b0;
            led       <= 8'h00;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_take) begin
                        state <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    if (out_xfer) begin
                        if (hdr_idx == LAST_HDR_IDX) begin
                            hdr_idx   <= '0;
                            first_pay <= 1'b1;
                            state     <= ST_PAY;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (out_xfer) begin
                        first_pay <= 1'b0;
                        // LEDs show the first payload byte of each reply
                        if (first_pay) begin
                            led <= pay_rd_data[7:0];
                        end
                        if (pay_rd_data[8]) begin
                            state <= hdr_take ? ST_HDR : ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* udp_echo_core.sv */
// UDP echo responder top: receive filter, header and payload queues,
// reply framer
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic       clk_125mhz,
    input  logic       rst_125mhz,

    // Received frames, no preamble or FCS
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,

    // Reply frames
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       out_last,

    output logic [7:0] led
);

    // Filter to queues
    hdr_u       hdr_wr_data;
    logic       hdr_wr_valid;
    logic       hdr_wr_ready;
    logic [8:0] pay_wr_data;
    logic       pay_wr_valid;
    logic       pay_wr_ready;

    // Queues to framer
    hdr_u       hdr_rd_data;
    logic       hdr_rd_valid;
    logic       hdr_rd_ready;
    logic [8:0] pay_rd_data;
    logic       pay_rd_valid;
    logic       pay_rd_ready;

    udp_rx_filter rx_filter (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .hdr_wr_data  (hdr_wr_data),
        .hdr_wr_valid (hdr_wr_valid),
        .hdr_wr_ready (hdr_wr_ready),
        .pay_wr_data  (pay_wr_data),
        .pay_wr_valid (pay_wr_valid),
        .pay_wr_ready (pay_wr_ready)
    );

    // Payload byte plus last flag
    sync_fifo #(
        .WIDTH (9),
        .DEPTH (`PAYLOAD_FIFO_DEPTH)
    ) payload_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_data    (pay_wr_data),
        .wr_valid   (pay_wr_valid),
        .wr_ready   (pay_wr_ready),
        .rd_data    (pay_rd_data),
        .rd_valid   (pay_rd_valid),
        .rd_ready   (pay_rd_ready)
    );

    // One entry per reply in flight
    sync_fifo #(
        .WIDTH ($bits(hdr_u)),
        .DEPTH (`HDR_FIFO_DEPTH)
    ) hdr_fifo (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .wr_data    (hdr_wr_data),
        .wr_valid   (hdr_wr_valid),
        .wr_ready   (hdr_wr_ready),
        .rd_data    (hdr_rd_data),
        .rd_valid   (hdr_rd_valid),
        .rd_ready   (hdr_rd_ready)
    );

    udp_reply_framer reply_framer (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .hdr_rd_data  (hdr_rd_data),
        .hdr_rd_valid (hdr_rd_valid),
        .hdr_rd_ready (hdr_rd_ready),
        .pay_rd_data  (pay_rd_data),
        .pay_rd_valid (pay_rd_valid),
        .pay_rd_ready (pay_rd_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .led          (led)
    );

endmodule

/* udp_echo_tb_frames.svh */
// Testbench helpers: xorshift generator, random frame builder and
// reference model of the expected reply bytes
`ifndef UDP_ECHO_TB_FRAMES_SVH
`define UDP_ECHO_TB_FRAMES_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
endfunction

// Big-endian field access on the current frame
function automatic logic [47:0] get_be(input int off, input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[39:0], frame[off + i]};
    end
    return v;
endfunction

function automatic void put_be(input int off, input int n, input logic [47:0] v);
    for (int i = 0; i < n; i++) begin
        frame[off + i] = v[8 * (n - 1 - i) +: 8];
    end
endfunction

// Kinds 0 and 1 good, 2 wrong port, 3 wrong ethertype, 4 wrong IP, 5 short
function automatic void make_frame(input int kind);
    int pay_len;
    pay_len   = 1 + int'(next_rand() % 32'd64);
    frame_len = 42 + pay_len;
    for (int i = 0; i < frame_len; i++) begin
        frame[i] = 8'(next_rand());
    end
    put_be(0, 6, `LOCAL_MAC);
    put_be(12, 2, 48'((kind == 3) ? 16'h86dd : 16'h0800));
    frame[14] = 8'h45;
    put_be(16, 2, 48'(28 + pay_len));
    frame[23] = 8'd17;
    put_be(30, 4, 48'((kind == 4) ? (`LOCAL_IP + 32'd1) : `LOCAL_IP));
    put_be(36, 2, 48'((kind == 2) ? (`UDP_ECHO_PORT ^ 16'h0100) : `UDP_ECHO_PORT));
    put_be(38, 2, 48'(8 + pay_len));
    // Header only or cut off inside the header
    if (kind == 5) begin
        frame_len = 1 + int'(next_rand() % 32'd42);
    end
endfunction

// IPv4 header words sit at bytes 14 to 33
function automatic logic [15:0] ones_csum(input logic [335:0] r);
    logic [31:0] acc;
    acc = '0;
    for (int k = 14; k < 34; k += 2) begin
        acc = acc + {16'h0, r[335 - 8 * k -: 16]};
    end
    while (acc[31:16] != 16'h0) begin
        acc = {16'h0, acc[15:0]} + {16'h0, acc[31:16]};
    end
    return ~acc[15:0];
endfunction

function automatic void model_reply();
    logic [335:0] r;
    r = {get_be(6, 6), `LOCAL_MAC, 16'h0800, 8'h45, 8'h00, 16'(get_be(16, 2)),
         32'h0, 8'd64, 8'd17, 16'h0, `LOCAL_IP, 32'(get_be(26, 4)),
         16'(get_be(36, 2)), 16'(get_be(34, 2)), 16'(get_be(38, 2)), 16'h0};
    r[335 - 8 * 24 -: 16] = ones_csum(r);
    for (int k = 0; k < 42; k++) begin
        exp_q.push_back({1'b0, r[335 - 8 * k -: 8]});
    end
    for (int i = 42; i < frame_len; i++) begin
        exp_q.push_back({i == frame_len - 1, frame[i]});
    end
    led_q.push_back(frame[42]);
endfunction

`endif

/* udp_echo_tb.sv */
// Testbench for the UDP echo responder: random frames, reply checker
// against a reference model, timeout and pass/fail report
`timescale 1ns/1ps
`include "udp_echo_config.svh"

module udp_echo_tb;

    localparam int NUM_FRAMES = 200;
    // 106 bytes in the longest frame, 4 cycles per byte
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 106 * 4;
    localparam logic [31:0] SEED = 32'ha6a7_8520;

    logic        clk_125mhz;
    logic        rst_125mhz;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_ready = 1'b0;
    logic        out_last;
    logic [7:0]  led;

    logic [31:0] rng;
    logic [31:0] stall_rng = SEED ^ 32'h3c3c_3c3c;
    logic [7:0]  frame [106];
    int          frame_len;
    logic [8:0]  exp_q [$];
    logic [7:0]  led_q [$];
    logic [8:0]  exp_byte;
    logic        led_check = 1'b0;
    logic [7:0]  led_exp;
    int          out_idx = 0;
    int          cycle_cnt = 0;

    `include "udp_echo_tb_frames.svh"

    udp_echo_core UUT (
        .clk_125mhz (clk_125mhz),
        .rst_125mhz (rst_125mhz),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_last    (in_last),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .led        (led)
    );

    always #4 clk_125mhz = ~clk_125mhz;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] data, input logic last);
        logic done;
        while ((next_rand() % 32'd4) == 32'd0) begin
            in_valid = 1'b0;
            @(posedge clk_125mhz);
            #1;
        end
        in_data  = data;
        in_last  = last;
        in_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk_125mhz);
            done = in_ready;
            @(posedge clk_125mhz);
            #1;
        end
        in_valid = 1'b0;
    endtask

    always @(posedge clk_125mhz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    // Random back-pressure on the reply stream
    always @(posedge clk_125mhz) begin
        #1;
        stall_rng = xorshift32(stall_rng);
        out_ready = (stall_rng[1:0] != 2'b00);
    end

    // Reply checker, sampled between edges
    always @(negedge clk_125mhz) begin
        if (led_check) begin
            assert (led == led_exp) else fail_run($sformatf(
                "Mismatch at %0t ns: led %02h after reply, expected %02h",
                $time, led, led_exp));
            led_check = 1'b0;
        end
        if (!rst_125mhz && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else fail_run("Reply byte seen with no reply expected");
            exp_byte = exp_q.pop_front();
            assert ({out_last, out_data} == exp_byte) else fail_run($sformatf(
                "Mismatch at %0t ns: reply byte %0d last/data %03h, expected %03h",
                $time, out_idx, {out_last, out_data}, exp_byte));
            out_idx++;
            if (exp_byte[8]) begin
                out_idx   = 0;
                led_exp   = led_q.pop_front();
                led_check = 1'b1;
            end
        end
    end

    initial begin
        int kind;
        clk_125mhz = 1'b0;
        rst_125mhz = 1'b1;
        in_data    = 8'h00;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        rng        = SEED;
        repeat (4) @(posedge clk_125mhz);
        #1;
        rst_125mhz = 1'b0;
        // Quiet outputs before the first frame
        repeat (8) begin
            @(negedge clk_125mhz);
            assert (!out_valid && led == 8'h00 && in_ready) else fail_run($sformatf(
                "Mismatch at %0t ns: idle after reset, out_valid %0b led %02h in_ready %0b",
                $time, out_valid, led, in_ready));
        end
        @(posedge clk_125mhz);
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            kind = int'(next_rand() % 32'd6);
            make_frame(kind);
            if (kind < 2) begin
                model_reply();
            end
            for (int i = 0; i < frame_len; i++) begin
                send_byte(frame[i], i == frame_len - 1);
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge clk_125mhz);
        end
        // Room for any stray reply byte to show up
        repeat (200) @(posedge clk_125mhz);
        $display("sim passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
udp_echo_pkg.sv
sync_fifo.sv
udp_rx_filter.sv
udp_reply_framer.sv
udp_echo_core.sv
udp_echo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the UDP echo testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module udp_echo_tb -o udp_echo_sim
./obj_dir/udp_echo_sim
